/* Bender.yml */
package:
  name: ifetch

sources:
  - design/ifetch_pkg.sv
  - design/fetch_fifo.sv
  - design/fetch_req_counter.sv
  - design/fetch_bus_fsm.sv
  - design/ir_assembler.sv
  - design/ifetch_top.sv
  - target: test
    files:
      - tests/wb_mem_model.sv
      - tests/tb_ifetch.sv

/* design/fetch_bus_fsm.sv */
`timescale 1ns/1ps

module fetch_bus_fsm #(
  parameter int                            REQ_MAX    = 4,
  parameter logic [ifetch_pkg::ADDR_W-1:0] START_ADDR = 32'h7000_0000,
  parameter int                            FIFO_AW    = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          pc_set_i,
  input  logic [ifetch_pkg::ADDR_W-1:0] pc_in_i,
  input  logic                          halt_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_stall_i,
  input  logic [FIFO_AW:0]              level_i,
  input  logic                          last_req_i,
  input  logic                          drained_i,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic [ifetch_pkg::ADDR_W-1:0] wb_adr_o,
  output logic                          req_o,
  output logic                          clear_o,
  output logic                          push_o
);

  import ifetch_pkg::*;

  localparam int DEPTH = 1 << FIFO_AW;

  bus_state_t state_q;
  bus_state_t state_d;
  logic       room;     // fifo can take a whole burst
  logic       busy;     // acks still owed after this cycle
  logic       redirect;

  assign wb_cyc_o = (state_q == BUS_FETCH) || (state_q == BUS_END) || (state_q == BUS_ABORT);
  assign wb_stb_o = (state_q == BUS_FETCH);
  assign req_o    = wb_stb_o && !wb_stall_i;
  assign clear_o  = (state_q == BUS_IDLE);
  assign push_o   = wb_ack_i && wb_cyc_o && (state_q != BUS_ABORT); // stale acks dropped
  assign room     = (int'(level_i) + REQ_MAX) <= DEPTH;
  assign busy     = !drained_i || req_o;
  assign redirect = pc_set_i && (state_q != BUS_HALT);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      BUS_IDLE:
      begin
        if (halt_i)
          state_d = BUS_HALT;
        else if (room)
          state_d = BUS_FETCH;
      end
      BUS_FETCH:
        if (last_req_i)
          state_d = BUS_END;
      BUS_END:
        if (drained_i)
          state_d = halt_i ? BUS_HALT : BUS_IDLE;
      BUS_ABORT:
        if (drained_i)
          state_d = BUS_IDLE;
      default:
        state_d = BUS_HALT; // held until reset
    endcase
    if (redirect)
      state_d = busy ? BUS_ABORT : BUS_IDLE;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q  <= BUS_IDLE;
      wb_adr_o <= START_ADDR;
    end
    else
    begin
      state_q <= state_d;
      if (redirect)
        wb_adr_o <= pc_in_i;
      else if (req_o)
        wb_adr_o <= wb_adr_o + ADDR_W'(ADDR_STEP);
    end
  end

  if (REQ_MAX > DEPTH)
  begin : g_burst_check
    $error("burst length exceeds fifo depth");
  end

  a_stb_in_cyc : assert property (@(posedge clk_i) disable iff (rst_i)
    wb_stb_o |-> wb_cyc_o);

  // back-pressure holds the request unless a redirect kills it
  a_adr_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    wb_stb_o && wb_stall_i && !pc_set_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

/* design/fetch_fifo.sv */
`timescale 1ns/1ps

module fetch_fifo #(
  parameter int FIFO_AW = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          flush_i,
  input  logic                          push_i,
  input  logic [ifetch_pkg::WORD_W-1:0] data_i,
  input  logic                          pop_i,
  output logic [ifetch_pkg::WORD_W-1:0] head_o,
  output logic                          empty_o,
  output logic [FIFO_AW:0]              level_o
);

  import ifetch_pkg::*;

  localparam logic [FIFO_AW:0] DEPTH = 1 << FIFO_AW;

  logic [WORD_W-1:0]  mem [0:DEPTH-1];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full    = (count == DEPTH);
  assign empty_o = (count == '0);
  assign level_o = count;
  assign head_o  = mem[rd_ptr]; // oldest word, falls through
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !empty_o && !flush_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (flush_i) // flush beats push
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem[wr_ptr] <= data_i;
  end

  a_no_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
    push_i && !flush_i |-> !full);

  a_no_underflow : assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

endmodule

/* design/fetch_req_counter.sv */
`timescale 1ns/1ps

module fetch_req_counter #(
  parameter int REQ_MAX = 4
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic clear_i,
  input  logic req_i,
  input  logic ack_i,
  output logic last_req_o,
  output logic drained_o
);

  localparam int CNT_W = $clog2(REQ_MAX + 1);

  logic [CNT_W-1:0] req_cnt; // requests accepted this burst
  logic [CNT_W-1:0] ack_cnt;

  // request accepted now is the final one of the burst
  assign last_req_o = req_i && (req_cnt == CNT_W'(REQ_MAX - 1));
  assign drained_o  = (req_cnt == ack_cnt);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      req_cnt <= '0;
      ack_cnt <= '0;
    end
    else if (clear_i)
    begin
      req_cnt <= '0;
      ack_cnt <= '0;
    end
    else
    begin
      if (req_i)
        req_cnt <= req_cnt + 1'b1;
      if (ack_i)
        ack_cnt <= ack_cnt + 1'b1;
    end
  end

  // an ack always answers an earlier or simultaneous request
  a_ack_le_req : assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i && !clear_i |-> (ack_cnt < req_cnt) || req_i);

endmodule

/* design/ifetch_pkg.sv */
package ifetch_pkg;

  localparam int WORD_W    = 32; // bus data width
  localparam int ADDR_W    = 32;
  localparam int IR_W      = 64; // long instr is two words
  localparam int ADDR_STEP = 4;  // bytes per word
  localparam int LONG_BIT  = 0;  // set on first half of a long instr

  // bus side FSM
  typedef enum logic [2:0] {
    BUS_IDLE,
    BUS_FETCH,
    BUS_END,
    BUS_ABORT,
    BUS_HALT
  } bus_state_t;

  // cpu side assembler
  typedef enum logic [1:0] {
    ASM_RESET,
    ASM_FETCH,
    ASM_FETCH2
  } asm_state_t;

endpackage

/* design/ifetch_top.sv */
`timescale 1ns/1ps

module ifetch_top #(
  parameter int                            REQ_MAX    = 4,
  parameter logic [ifetch_pkg::ADDR_W-1:0] START_ADDR = 32'h7000_0000,
  parameter int                            FIFO_AW    = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic [ifetch_pkg::ADDR_W-1:0] wb_adr_o,
  input  logic [ifetch_pkg::WORD_W-1:0] wb_dat_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_stall_i,
  input  logic                          pc_set_i,
  input  logic [ifetch_pkg::ADDR_W-1:0] pc_in_i,
  input  logic                          stall_i,
  input  logic                          halt_i,
  output logic [ifetch_pkg::IR_W-1:0]   ir_o,
  output logic                          ir_valid_o,
  output logic [ifetch_pkg::ADDR_W-1:0] pc_o
);

  import ifetch_pkg::*;

  logic              req;
  logic              clear;
  logic              push;
  logic              pop;
  logic              last_req;
  logic              drained;
  logic              empty;
  logic [FIFO_AW:0]  level;
  logic [WORD_W-1:0] head;

  fetch_bus_fsm #(
    .REQ_MAX    (REQ_MAX),
    .START_ADDR (START_ADDR),
    .FIFO_AW    (FIFO_AW)
  ) u_bus_fsm (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .pc_set_i   (pc_set_i),
    .pc_in_i    (pc_in_i),
    .halt_i     (halt_i),
    .wb_ack_i   (wb_ack_i),
    .wb_stall_i (wb_stall_i),
    .level_i    (level),
    .last_req_i (last_req),
    .drained_i  (drained),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_adr_o   (wb_adr_o),
    .req_o      (req),
    .clear_o    (clear),
    .push_o     (push)
  );

  fetch_req_counter #(
    .REQ_MAX (REQ_MAX)
  ) u_req_counter (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .clear_i    (clear),
    .req_i      (req),
    .ack_i      (wb_ack_i),
    .last_req_o (last_req),
    .drained_o  (drained)
  );

  fetch_fifo #(
    .FIFO_AW (FIFO_AW)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (pc_set_i), // redirect drops buffered words
    .push_i  (push),
    .data_i  (wb_dat_i),
    .pop_i   (pop),
    .head_o  (head),
    .empty_o (empty),
    .level_o (level)
  );

  ir_assembler #(
    .START_ADDR (START_ADDR)
  ) u_asm (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .pc_set_i   (pc_set_i),
    .pc_in_i    (pc_in_i),
    .stall_i    (stall_i),
    .head_i     (head),
    .empty_i    (empty),
    .pop_o      (pop),
    .ir_o       (ir_o),
    .ir_valid_o (ir_valid_o),
    .pc_o       (pc_o)
  );

  // once halted the bus stays quiet and the fifo only drains
  a_halt_bus_quiet : assert property (@(posedge clk_i) disable iff (rst_i)
    u_bus_fsm.state_q == BUS_HALT |=> !wb_cyc_o && (level <= $past(level)));

  a_abort_no_fill : assert property (@(posedge clk_i) disable iff (rst_i)
    u_bus_fsm.state_q == BUS_ABORT |=> level <= $past(level));

endmodule

/* design/ir_assembler.sv */
`timescale 1ns/1ps

module ir_assembler #(
  parameter logic [ifetch_pkg::ADDR_W-1:0] START_ADDR = 32'h7000_0000
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          pc_set_i,
  input  logic [ifetch_pkg::ADDR_W-1:0] pc_in_i,
  input  logic                          stall_i,
  input  logic [ifetch_pkg::WORD_W-1:0] head_i,
  input  logic                          empty_i,
  output logic                          pop_o,
  output logic [ifetch_pkg::IR_W-1:0]   ir_o,
  output logic                          ir_valid_o,
  output logic [ifetch_pkg::ADDR_W-1:0] pc_o
);

  import ifetch_pkg::*;

  asm_state_t        state_q;
  asm_state_t        state_d;
  logic [WORD_W-1:0] low_q;    // first half of a long instr
  logic [IR_W-1:0]   ir_d;
  logic              valid_d;
  logic              load_low;

  assign pop_o = !stall_i && !empty_i && !pc_set_i && (state_q != ASM_RESET);

  always_comb
  begin
    state_d  = state_q;
    ir_d     = '0;          // bubble unless an instr completes
    valid_d  = 1'b0;
    load_low = 1'b0;
    case (state_q)
      ASM_RESET:
        state_d = ASM_FETCH;
      ASM_FETCH:
        if (pop_o)
        begin
          if (head_i[LONG_BIT])
          begin
            load_low = 1'b1;
            state_d  = ASM_FETCH2;
          end
          else
          begin
            ir_d    = {{(IR_W - WORD_W){1'b0}}, head_i};
            valid_d = 1'b1;
          end
        end
      ASM_FETCH2:
        if (pop_o)
        begin
          ir_d    = {head_i, low_q}; // second word on top
          valid_d = 1'b1;
          state_d = ASM_FETCH;
        end
      default:
        state_d = ASM_RESET;
    endcase
    if (pc_set_i)
      state_d = ASM_RESET;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q    <= ASM_RESET;
      pc_o       <= START_ADDR;
      ir_o       <= '0;
      ir_valid_o <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      ir_o       <= ir_d;
      ir_valid_o <= valid_d;
      if (pc_set_i)
        pc_o <= pc_in_i;
      else if (pop_o)
        pc_o <= pc_o + ADDR_W'(ADDR_STEP); // past last consumed word
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load_low)
      low_q <= head_i;
  end

  a_redirect_bubble : assert property (@(posedge clk_i) disable iff (rst_i)
    pc_set_i |=> !ir_valid_o);

endmodule

/* ifetch.f */
design/ifetch_pkg.sv
design/fetch_fifo.sv
design/fetch_req_counter.sv
design/fetch_bus_fsm.sv
design/ir_assembler.sv
design/ifetch_top.sv
tests/wb_mem_model.sv
tests/tb_ifetch.sv

/* tests/tb_ifetch.sv */
`timescale 1ns/1ps

module tb_ifetch;

  import ifetch_pkg::*;

  localparam logic [ADDR_W-1:0] START_ADDR = 32'h7000_0000;
  localparam int WATCHDOG_CYCLES = 20000; // whole run needs well under 5000
  localparam int HALT_LIMIT      = 100;   // cycles for the last burst to drain

  logic              clk;
  logic              rst;
  logic              wb_cyc;
  logic              wb_stb;
  logic [ADDR_W-1:0] wb_adr;
  logic [WORD_W-1:0] wb_dat;
  logic              wb_ack;
  logic              wb_stall;
  logic              pc_set;
  logic [ADDR_W-1:0] pc_in;
  logic              stall;
  logic              halt;
  logic [IR_W-1:0]   ir;
  logic              ir_valid;
  logic [ADDR_W-1:0] pc;

  logic [ADDR_W-1:0] exp_e;       // address of the next expected instr
  logic [IR_W-1:0]   exp_ir;
  logic [ADDR_W-1:0] exp_pc;
  logic [ADDR_W-1:0] chk_adr;     // address the next stb must carry
  logic              adr_pending;
  logic [ADDR_W-1:0] pc_last;
  int                halt_wait = 0;
  int                n_instr   = 0;
  int                n_split   = 0;
  int                errors    = 0;
  integer            seed      = 32'he1ea;

  ifetch_top #(
    .REQ_MAX    (4),
    .START_ADDR (START_ADDR),
    .FIFO_AW    (4)
  ) uut (
    .clk_i      (clk),
    .rst_i      (rst),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_adr_o   (wb_adr),
    .wb_dat_i   (wb_dat),
    .wb_ack_i   (wb_ack),
    .wb_stall_i (wb_stall),
    .pc_set_i   (pc_set),
    .pc_in_i    (pc_in),
    .stall_i    (stall),
    .halt_i     (halt),
    .ir_o       (ir),
    .ir_valid_o (ir_valid),
    .pc_o       (pc)
  );

  wb_mem_model u_mem (
    .clk_i   (clk),
    .rst_i   (rst),
    .cyc_i   (wb_cyc),
    .stb_i   (wb_stb),
    .adr_i   (wb_adr),
    .dat_o   (wb_dat),
    .ack_o   (wb_ack),
    .stall_o (wb_stall)
  );

  function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
    mem_word = {a[31:2], 1'b0, a[3] ^ a[4]};
  endfunction

  function automatic logic [IR_W-1:0] expect_ir(input logic [ADDR_W-1:0] e);
    logic [WORD_W-1:0] w0;
    w0 = mem_word(e);
    if (w0[LONG_BIT])
      expect_ir = {mem_word(e + 32'd4), w0}; // second word on top
    else
      expect_ir = {{(IR_W - WORD_W){1'b0}}, w0};
  endfunction

  function automatic logic [ADDR_W-1:0] next_addr(input logic [ADDR_W-1:0] e);
    logic [WORD_W-1:0] w0;
    w0 = mem_word(e);
    next_addr = w0[LONG_BIT] ? e + 32'd8 : e + 32'd4;
  endfunction

  assign exp_ir = expect_ir(exp_e);
  assign exp_pc = next_addr(exp_e);

  task automatic report_mismatch(input string name, input logic [IR_W-1:0] expv,
                                 input logic [IR_W-1:0] gotv);
    errors++;
    $display("ERR %0t %s expected %h got %h", $time, name, expv, gotv);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%0t: %s", $time, what);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reference model state, follows the stream the DUT should deliver
  always @(posedge clk)
  begin
    pc_last <= pc;
    if (rst)
    begin
      exp_e       <= START_ADDR;
      chk_adr     <= START_ADDR;
      adr_pending <= 1'b1;
    end
    else
    begin
      if (pc_set)
      begin
        exp_e       <= pc_in;
        chk_adr     <= pc_in;
        adr_pending <= 1'b1;
        if (uut.u_asm.state_q == ASM_FETCH2)
          n_split <= n_split + 1; // landed between two halves
      end
      else
      begin
        if (ir_valid)
          exp_e <= exp_pc;
        if (wb_stb)
          adr_pending <= 1'b0;
      end
      if (ir_valid)
        n_instr <= n_instr + 1;
      if (halt && wb_cyc)
        halt_wait <= halt_wait + 1;
    end
  end

  a_reset_idle : assert property (@(posedge clk) $fell(rst) |-> !wb_cyc && !wb_stb && !ir_valid)
    else report_failure("bus or ir_valid_o active right after reset");
  a_reset_pc : assert property (@(posedge clk) $fell(rst) |-> pc == START_ADDR)
    else report_mismatch("pc_o", START_ADDR, $sampled(pc));
  a_stb_adr : assert property (@(posedge clk) disable iff (rst)
    adr_pending && wb_stb |-> wb_adr == chk_adr)
    else report_mismatch("wb_adr_o", $sampled(chk_adr), $sampled(wb_adr));
  a_ir_value : assert property (@(posedge clk) disable iff (rst) ir_valid |-> ir == exp_ir)
    else report_mismatch("ir_o", $sampled(exp_ir), $sampled(ir));
  a_pc_value : assert property (@(posedge clk) disable iff (rst) ir_valid |-> pc == exp_pc)
    else report_mismatch("pc_o", $sampled(exp_pc), $sampled(pc));
  a_bubble : assert property (@(posedge clk) disable iff (rst) !ir_valid |-> ir == '0)
    else report_mismatch("ir_o", '0, $sampled(ir));
  a_redirect_gap : assert property (@(posedge clk) disable iff (rst) pc_set |=> !ir_valid)
    else report_failure("ir_valid_o high in the cycle after a redirect");
  a_stall_valid : assert property (@(posedge clk) disable iff (rst)
    stall && !pc_set |=> !ir_valid)
    else report_failure("ir_valid_o high while the pipeline was stalled");
  a_stall_pc : assert property (@(posedge clk) disable iff (rst)
    stall && !pc_set |=> pc == pc_last)
    else report_mismatch("pc_o", $sampled(pc_last), $sampled(pc));
  a_halt_quiet : assert property (@(posedge clk) disable iff (rst)
    halt && !wb_cyc && !pc_set |=> !wb_cyc && !wb_stb)
    else report_failure("bus became active again after halt");
  a_halt_drain : assert property (@(posedge clk) disable iff (rst) halt |-> halt_wait < HALT_LIMIT)
    else report_failure("bus cycle did not end after halt");

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic run_with_stalls(input int cycles);
    int left;
    int len;
    left = cycles;
    while (left > 0)
    begin
      len   = 1 + int'($unsigned($random(seed)) % 24);
      stall = (($random(seed) & 32'd1) != 0);
      step(len);
      left  = left - len;
    end
    stall = 1'b0;
  endtask

  task automatic wait_long_half(input int limit);
    int n;
    n = 0;
    while (uut.u_asm.state_q != ASM_FETCH2 && n < limit)
    begin
      step(1);
      n++;
    end
  endtask

  task automatic wait_bus_cycle(input int limit);
    int n;
    n = 0;
    while (!wb_cyc && n < limit)
    begin
      step(1);
      n++;
    end
  endtask

  task automatic redirect_to(input logic [ADDR_W-1:0] target);
    pc_set = 1'b1;
    pc_in  = target;
    step(1);
    pc_set = 1'b0;
  endtask

  initial
  begin
    int          i;
    logic [31:0] target;
    rst    = 1'b1;
    pc_set = 1'b0;
    pc_in  = '0;
    stall  = 1'b0;
    halt   = 1'b0;
    step(5);
    rst = 1'b0;
    step(300);
    run_with_stalls(400);
    for (i = 0; i < 24; i++)
    begin
      step(1 + int'($unsigned($random(seed)) % 8));
      if (i % 2 == 0)
        wait_long_half(64);
      else
        wait_bus_cycle(64);
      target = START_ADDR + (($unsigned($random(seed)) % 4096) << 2);
      redirect_to(target);
      if (i % 3 == 0)
        run_with_stalls(30);
      else
        step(30);
    end
    halt = 1'b1;
    run_with_stalls(100);
    step(100);
    if (n_instr < 200)
      report_failure("too few instructions delivered");
    if (n_split == 0)
      report_failure("no redirect landed between the halves of a long instruction");
    $display("errors: %0d  instructions: %0d  split redirects: %0d", errors, n_instr, n_split);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run still going after %0d cycles, errors: %0d", WATCHDOG_CYCLES, errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* tests/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model #(
  parameter int MAX_LAT = 3
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic [31:0] adr_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        stall_o
);

  logic [31:0] adr_q [$]; // accepted, not yet acked
  int          due_q [$]; // earliest ack cycle per request
  int          cycle;
  integer      seed;

  // word at byte address a, bit 0 marks the first half of a long instr
  function automatic logic [31:0] word_at(input logic [31:0] a);
    word_at = {a[31:2], 1'b0, a[3] ^ a[4]};
  endfunction

  initial
  begin
    seed    = 32'he1ea;
    cycle   = 0;
    dat_o   = '0;
    ack_o   = 1'b0;
    stall_o = 1'b0;
  end

  always @(posedge clk_i)
  begin
    cycle = cycle + 1;
    if (rst_i || !cyc_i) // dropped cyc ends the cycle
    begin
      adr_q.delete();
      due_q.delete();
    end
    else if (stb_i && !stall_o)
    begin
      adr_q.push_back(adr_i);
      due_q.push_back(cycle + int'($unsigned($random(seed)) % (MAX_LAT + 1)));
    end
    #1;
    ack_o = 1'b0;
    dat_o = '0;
    // acks leave in request order, a late head holds back the rest
    if (adr_q.size() != 0 && due_q[0] <= cycle)
    begin
      ack_o = 1'b1;
      dat_o = word_at(adr_q.pop_front());
      void'(due_q.pop_front());
    end
    stall_o = (($random(seed) & 32'd3) == 0); // about one cycle in four
  end

endmodule
